//--- mips_lite.f
mips_pkg.sv
mips_pipe_reg.sv
mips_fetch.sv
mips_regfile.sv
mips_decode.sv
mips_execute.sv
mips_result.sv
mips_core.sv
mips_tb.sv

//--- Makefile
SRCS := $(shell cat mips_lite.f)

obj_dir/Vmips_tb: mips_lite.f $(SRCS)
	verilator --binary --timing --top-module mips_tb -f mips_lite.f -o Vmips_tb

run: obj_dir/Vmips_tb
	obj_dir/Vmips_tb | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- mips_input.hex
// program words from word 0, expected records from word 0x80
// records: 1 pc reg value (register write), 2 addr value (store), 0 ends the list
@00
3c011234 34215678 2402fffd 00221821
00412023 00642824 00643025 00c13826
0041402a 0022482a 00015100 24200001
00085821 240c0100 ad810000 ad870004
8d8d0000 01ad7021 8d8f0004 11e70003
24100007 24110055 24110066 16000002
26120001 24130077 11090004 24130099
0270a023 08000021 3415beef 24150001
24150002 ad950008 8d960008 26d70010
08000024 00000000
@80
1 00000000 01 12340000
1 00000004 01 12345678
1 00000008 02 fffffffd
1 0000000c 03 12345675
1 00000010 04 edcba985
1 00000014 05 00000005
1 00000018 06 fffffff5
1 0000001c 07 edcba98d
1 00000020 08 00000001
1 00000024 09 00000000
1 00000028 0a 23456780
1 00000030 0b 00000001
1 00000034 0c 00000100
2 00000100 12345678
2 00000104 edcba98d
1 00000040 0d 12345678
1 00000044 0e 2468acf0
1 00000048 0f edcba98d
1 00000050 10 00000007
1 00000060 12 00000008
1 0000006c 13 00000099
1 00000070 14 00000092
1 00000078 15 0000beef
2 00000108 0000beef
1 00000088 16 0000beef
1 0000008c 17 0000beff
0

//--- mips_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_tb;

	localparam int IMAGE_WORDS = 256;
	localparam int REC_BASE = 128;
	localparam int DMEM_WORDS = 256;
	localparam int EVENT_TIMEOUT = 200;

	logic clk = 1'b0;
	logic rst = 1'b1;

	logic                inst_sram_en;
	mips_pkg::word_t     inst_sram_addr;
	mips_pkg::word_t     inst_sram_rdata = '0;
	logic                data_sram_en;
	logic [3:0]          data_sram_wen;
	mips_pkg::word_t     data_sram_addr;
	mips_pkg::word_t     data_sram_wdata;
	mips_pkg::word_t     data_sram_rdata = '0;
	mips_pkg::word_t     debug_wb_pc;
	logic [3:0]          debug_wb_rf_wen;
	mips_pkg::reg_addr_t debug_wb_rf_wnum;
	mips_pkg::word_t     debug_wb_rf_wdata;

	// program in the low half and expected records from REC_BASE
	mips_pkg::word_t mem_image [IMAGE_WORDS];
	mips_pkg::word_t dmem [DMEM_WORDS];

	mips_pkg::word_t     wr_pc_q [$];
	mips_pkg::reg_addr_t wr_reg_q [$];
	mips_pkg::word_t     wr_val_q [$];
	mips_pkg::word_t     st_addr_q [$];
	mips_pkg::word_t     st_val_q [$];

	int checks = 0;
	int errors = 0;
	int n_writes = 0;
	int n_stores = 0;
	bit seen;

	always #4 clk = ~clk;

	mips_core dut0 (
		.clk              (clk),
		.rst              (rst),
		.inst_sram_en     (inst_sram_en),
		.inst_sram_addr   (inst_sram_addr),
		.inst_sram_rdata  (inst_sram_rdata),
		.data_sram_en     (data_sram_en),
		.data_sram_wen    (data_sram_wen),
		.data_sram_addr   (data_sram_addr),
		.data_sram_wdata  (data_sram_wdata),
		.data_sram_rdata  (data_sram_rdata),
		.debug_wb_pc      (debug_wb_pc),
		.debug_wb_rf_wen  (debug_wb_rf_wen),
		.debug_wb_rf_wnum (debug_wb_rf_wnum),
		.debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	////////////////////////////////////////////////////////////////////////////
	// sram models take the request at the rising edge and drive data at the falling edge

	logic            inst_req_en = 1'b0;
	mips_pkg::word_t inst_req_addr = '0;
	logic            data_req_en = 1'b0;
	logic [3:0]      data_req_wen = 4'b0;
	mips_pkg::word_t data_req_addr = '0;
	mips_pkg::word_t data_req_wdata = '0;

	always @(posedge clk) begin
		inst_req_en    <= inst_sram_en;
		inst_req_addr  <= inst_sram_addr;
		data_req_en    <= data_sram_en;
		data_req_wen   <= data_sram_wen;
		data_req_addr  <= data_sram_addr;
		data_req_wdata <= data_sram_wdata;
	end

	always @(negedge clk) begin
		if (inst_req_en) begin
			inst_sram_rdata <= mem_image[inst_req_addr[8:2]];
		end
		if (data_req_en) begin
			data_sram_rdata <= dmem[data_req_addr[9:2]];
			if (data_req_wen == 4'hf) begin
				dmem[data_req_addr[9:2]] <= data_req_wdata;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks

	task automatic check_write(
		input string               name,
		input mips_pkg::word_t     exp_pc,
		input mips_pkg::reg_addr_t exp_reg,
		input mips_pkg::word_t     exp_val,
		input mips_pkg::word_t     act_pc,
		input mips_pkg::reg_addr_t act_reg,
		input mips_pkg::word_t     act_val
	);
		checks++;
		if (exp_pc !== act_pc || exp_reg !== act_reg || exp_val !== act_val) begin
			errors++;
			$display("mismatch %s expected pc %h r%0d %h actual pc %h r%0d %h",
				name, exp_pc, exp_reg, exp_val, act_pc, act_reg, act_val);
		end else begin
			$display("%s ok pc %h r%0d %h", name, act_pc, act_reg, act_val);
		end
	endtask

	task automatic check_store(
		input string           name,
		input mips_pkg::word_t exp_addr,
		input mips_pkg::word_t exp_val,
		input mips_pkg::word_t act_addr,
		input mips_pkg::word_t act_val
	);
		checks++;
		if (exp_addr !== act_addr || exp_val !== act_val) begin
			errors++;
			$display("mismatch %s expected addr %h data %h actual addr %h data %h",
				name, exp_addr, exp_val, act_addr, act_val);
		end else begin
			$display("%s ok addr %h data %h", name, act_addr, act_val);
		end
	endtask

	task automatic load_records();
		int idx;
		idx = REC_BASE;
		while (idx < IMAGE_WORDS - 4 && mem_image[idx] != 32'd0) begin
			if (mem_image[idx] == 32'd1) begin
				wr_pc_q.push_back(mem_image[idx + 1]);
				wr_reg_q.push_back(mips_pkg::reg_addr_t'(mem_image[idx + 2]));
				wr_val_q.push_back(mem_image[idx + 3]);
				idx += 4;
			end else if (mem_image[idx] == 32'd2) begin
				st_addr_q.push_back(mem_image[idx + 1]);
				st_val_q.push_back(mem_image[idx + 2]);
				idx += 3;
			end else begin
				errors++;
				$display("unknown record tag %h at word %0d of the data file",
					mem_image[idx], idx);
				break;
			end
		end
	endtask

	// wait for the next register write or store
	task automatic wait_for_event(output bit found);
		int idle;
		idle = 0;
		found = 1'b0;
		while (!found && idle < EVENT_TIMEOUT) begin
			@(negedge clk);
			if (debug_wb_rf_wen != 4'b0 || data_sram_wen != 4'b0) begin
				found = 1'b1;
			end else begin
				idle++;
			end
		end
	endtask

	task automatic take_event();
		mips_pkg::word_t     e_pc;
		mips_pkg::reg_addr_t e_reg;
		mips_pkg::word_t     e_val;
		if (debug_wb_rf_wen != 4'b0) begin
			if (debug_wb_rf_wen != 4'hf) begin
				errors++;
				$display("partial trace write enable %b at pc %h", debug_wb_rf_wen, debug_wb_pc);
			end else if (wr_pc_q.size() == 0) begin
				errors++;
				$display("unexpected register write r%0d at pc %h",
					debug_wb_rf_wnum, debug_wb_pc);
			end else begin
				e_pc = wr_pc_q.pop_front();
				e_reg = wr_reg_q.pop_front();
				e_val = wr_val_q.pop_front();
				check_write($sformatf("write %0d", n_writes), e_pc, e_reg, e_val,
					debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
				n_writes++;
			end
		end
		if (data_sram_wen != 4'b0) begin
			if (data_sram_wen != 4'hf || !data_sram_en) begin
				errors++;
				$display("malformed store request, en %b wen %b", data_sram_en, data_sram_wen);
			end else if (st_addr_q.size() == 0) begin
				errors++;
				$display("unexpected store to address %h", data_sram_addr);
			end else begin
				e_pc = st_addr_q.pop_front();
				e_val = st_val_q.pop_front();
				check_store($sformatf("store %0d", n_stores), e_pc, e_val,
					data_sram_addr, data_sram_wdata);
				n_stores++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		void'($urandom(32'hde60));
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = $urandom;
		end
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			mem_image[i] = '0;
		end
		$readmemh("mips_input.hex", mem_image);
		load_records();

		repeat (10) @(negedge clk);
		rst = 1'b0;

		seen = 1'b1;
		while (seen && (wr_pc_q.size() > 0 || st_addr_q.size() > 0)) begin
			wait_for_event(seen);
			if (seen) begin
				take_event();
			end
		end

		if (!seen) begin
			errors++;
			$display("timeout, no register write or store for %0d cycles, %0d records left",
				EVENT_TIMEOUT, wr_pc_q.size() + st_addr_q.size());
		end else begin
			// the program ends in a tight loop that retires nothing
			repeat (20) begin
				@(negedge clk);
				take_event();
			end
		end

		$display("summary: %0d checks, %0d writes, %0d stores, %0d errors",
			checks, n_writes, n_stores, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  logic                clk,
	input  logic                rst,
	// instruction sram
	output logic                inst_sram_en,
	output mips_pkg::word_t     inst_sram_addr,
	input  mips_pkg::word_t     inst_sram_rdata,
	// data sram
	output logic                data_sram_en,
	output logic [3:0]          data_sram_wen,
	output mips_pkg::word_t     data_sram_addr,
	output mips_pkg::word_t     data_sram_wdata,
	input  mips_pkg::word_t     data_sram_rdata,
	// writeback trace
	output mips_pkg::word_t     debug_wb_pc,
	output logic [3:0]          debug_wb_rf_wen,
	output mips_pkg::reg_addr_t debug_wb_rf_wnum,
	output mips_pkg::word_t     debug_wb_rf_wdata
);

	// instruction word and its pc
	typedef mips_pkg::word_t [1:0] fd_pair_t;

	mips_pkg::word_t f_pc;
	mips_pkg::word_t target;
	logic stall;
	logic redirect;

	fd_pair_t fd_in;
	fd_pair_t fd_out;
	logic fd_valid;

	mips_pkg::de_payload_t de_in;
	mips_pkg::de_payload_t de_out;
	logic de_valid;

	mips_pkg::em_payload_t em_in;
	mips_pkg::em_payload_t em_out;
	logic em_valid;

	mips_pkg::reg_addr_t rf_addr_a;
	mips_pkg::reg_addr_t rf_addr_b;
	mips_pkg::word_t rf_data_a;
	mips_pkg::word_t rf_data_b;

	mips_pkg::word_t mem_data;
	logic wb_valid;
	logic wb_reg_write;
	mips_pkg::reg_addr_t wb_dest;
	mips_pkg::word_t wb_data;

	////////////////////////////////////////////////////////////////////////////
	// fetch

	mips_fetch u_fetch (
		.clk           (clk),
		.rst           (rst),
		.hold          (stall),
		.redirect      (redirect),
		.target        (target),
		.pc            (f_pc),
		.inst_sram_en  (inst_sram_en),
		.inst_sram_addr(inst_sram_addr)
	);

	assign fd_in = {inst_sram_rdata, f_pc};

	mips_pipe_reg #(
		.payload_t(fd_pair_t)
	) u_fd_reg (
		.clk      (clk),
		.rst      (rst),
		.hold     (stall),
		.bubble   (1'b0),
		.in_valid (1'b1),
		.in_data  (fd_in),
		.out_valid(fd_valid),
		.out_data (fd_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// decode

	mips_decode u_decode (
		.inst         (fd_out[1]),
		.pc           (fd_out[0]),
		.in_valid     (fd_valid),
		.ex_dest      (de_out.dest),
		.ex_reg_write (de_out.reg_write),
		.ex_mem_read  (de_out.mem_read),
		.ex_valid     (de_valid),
		.mem_dest     (em_out.dest),
		.mem_reg_write(em_out.reg_write),
		.mem_mem_read (em_out.mem_read),
		.mem_valid    (em_valid),
		.mem_data     (mem_data),
		.wb_dest      (wb_dest),
		.wb_reg_write (wb_reg_write),
		.wb_valid     (wb_valid),
		.wb_data      (wb_data),
		.rf_addr_a    (rf_addr_a),
		.rf_addr_b    (rf_addr_b),
		.rf_data_a    (rf_data_a),
		.rf_data_b    (rf_data_b),
		.stall        (stall),
		.redirect     (redirect),
		.target       (target),
		.payload      (de_in)
	);

	mips_regfile u_regfile (
		.clk      (clk),
		.rd_addr_a(rf_addr_a),
		.rd_data_a(rf_data_a),
		.rd_addr_b(rf_addr_b),
		.rd_data_b(rf_data_b),
		.wr_en    (wb_reg_write),
		.wr_addr  (wb_dest),
		.wr_data  (wb_data)
	);

	// a stalled decode leaves a bubble in execute
	mips_pipe_reg #(
		.payload_t(mips_pkg::de_payload_t)
	) u_de_reg (
		.clk      (clk),
		.rst      (rst),
		.hold     (1'b0),
		.bubble   (stall),
		.in_valid (fd_valid),
		.in_data  (de_in),
		.out_valid(de_valid),
		.out_data (de_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// execute

	mips_execute u_execute (
		.in_valid       (de_valid),
		.payload        (de_out),
		.mem_alu        (em_out.alu),
		.data_sram_en   (data_sram_en),
		.data_sram_wen  (data_sram_wen),
		.data_sram_addr (data_sram_addr),
		.data_sram_wdata(data_sram_wdata),
		.result         (em_in)
	);

	mips_pipe_reg #(
		.payload_t(mips_pkg::em_payload_t)
	) u_em_reg (
		.clk      (clk),
		.rst      (rst),
		.hold     (1'b0),
		.bubble   (1'b0),
		.in_valid (de_valid),
		.in_data  (em_in),
		.out_valid(em_valid),
		.out_data (em_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// memory and writeback

	mips_result u_result (
		.clk              (clk),
		.rst              (rst),
		.in_valid         (em_valid),
		.payload          (em_out),
		.data_sram_rdata  (data_sram_rdata),
		.mem_data         (mem_data),
		.wb_valid         (wb_valid),
		.wb_dest          (wb_dest),
		.wb_reg_write     (wb_reg_write),
		.wb_data          (wb_data),
		.debug_wb_pc      (debug_wb_pc),
		.debug_wb_rf_wen  (debug_wb_rf_wen),
		.debug_wb_rf_wnum (debug_wb_rf_wnum),
		.debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

endmodule

`default_nettype wire

//--- mips_result.sv
`timescale 1ns/1ps
`default_nettype none

module mips_result (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  mips_pkg::em_payload_t payload,
	input  mips_pkg::word_t       data_sram_rdata,
	output mips_pkg::word_t       mem_data,
	output logic                  wb_valid,
	output mips_pkg::reg_addr_t   wb_dest,
	output logic                  wb_reg_write,
	output mips_pkg::word_t       wb_data,
	output mips_pkg::word_t       debug_wb_pc,
	output logic [3:0]            debug_wb_rf_wen,
	output mips_pkg::reg_addr_t   debug_wb_rf_wnum,
	output mips_pkg::word_t       debug_wb_rf_wdata
);

	mips_pkg::mw_payload_t mw_in;
	mips_pkg::mw_payload_t mw_out;
	logic mw_valid;

	// load word arrives from the sram while the load sits here
	assign mem_data = (payload.wb_sel == mips_pkg::WB_MEM) ? data_sram_rdata : payload.alu;

	always_comb begin
		mw_in.pc        = payload.pc;
		mw_in.dest      = payload.dest;
		mw_in.reg_write = payload.reg_write;
		mw_in.data      = mem_data;
	end

	mips_pipe_reg #(
		.payload_t(mips_pkg::mw_payload_t)
	) u_mw_reg (
		.clk      (clk),
		.rst      (rst),
		.hold     (1'b0),
		.bubble   (1'b0),
		.in_valid (in_valid),
		.in_data  (mw_in),
		.out_valid(mw_valid),
		.out_data (mw_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// writeback

	assign wb_valid     = mw_valid;
	assign wb_dest      = mw_out.dest;
	assign wb_reg_write = mw_valid && mw_out.reg_write;
	assign wb_data      = mw_out.data;

	// r0 writes are not traced
	assign debug_wb_pc       = mw_out.pc;
	assign debug_wb_rf_wen   = {4{wb_reg_write && mw_out.dest != '0}};
	assign debug_wb_rf_wnum  = mw_out.dest;
	assign debug_wb_rf_wdata = mw_out.data;

endmodule

`default_nettype wire

//--- mips_execute.sv
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
	input  logic                  in_valid,
	input  mips_pkg::de_payload_t payload,
	// alu result of the instruction now in memory
	input  mips_pkg::word_t       mem_alu,
	output logic                  data_sram_en,
	output logic [3:0]            data_sram_wen,
	output mips_pkg::word_t       data_sram_addr,
	output mips_pkg::word_t       data_sram_wdata,
	output mips_pkg::em_payload_t result
);

	mips_pkg::word_t reg_a;
	mips_pkg::word_t reg_b;
	mips_pkg::word_t src_a;
	mips_pkg::word_t src_b;
	mips_pkg::word_t alu;

	assign reg_a = payload.fwd_a ? mem_alu : payload.op_a;
	assign reg_b = payload.fwd_b ? mem_alu : payload.op_b;

	// sll shifts rt by the shift amount
	assign src_a = (payload.alu_op == mips_pkg::ALU_SLL) ? mips_pkg::word_t'(payload.shamt)
		: reg_a;
	assign src_b = payload.use_imm ? payload.imm : reg_b;

	always_comb begin
		alu = src_a + src_b;
		case (payload.alu_op)
			mips_pkg::ALU_SUB: alu = src_a - src_b;
			mips_pkg::ALU_AND: alu = src_a & src_b;
			mips_pkg::ALU_OR:  alu = src_a | src_b;
			mips_pkg::ALU_XOR: alu = src_a ^ src_b;
			mips_pkg::ALU_SLT: alu = mips_pkg::word_t'($signed(src_a) < $signed(src_b));
			mips_pkg::ALU_SLL: alu = src_b << src_a[4:0];
			mips_pkg::ALU_LUI: alu = {src_b[15:0], 16'h0000};
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// data sram request, word access only

	assign data_sram_en    = in_valid && (payload.mem_read || payload.mem_write);
	assign data_sram_wen   = {4{in_valid && payload.mem_write}};
	assign data_sram_addr  = alu;
	assign data_sram_wdata = reg_b;

	always_comb begin
		result.pc        = payload.pc;
		result.alu       = alu;
		result.dest      = payload.dest;
		result.reg_write = payload.reg_write;
		result.mem_read  = payload.mem_read;
		result.wb_sel    = payload.wb_sel;
	end

endmodule

`default_nettype wire

//--- mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
	input  mips_pkg::word_t       inst,
	input  mips_pkg::word_t       pc,
	input  logic                  in_valid,
	// instruction in execute
	input  mips_pkg::reg_addr_t   ex_dest,
	input  logic                  ex_reg_write,
	input  logic                  ex_mem_read,
	input  logic                  ex_valid,
	// instruction in memory
	input  mips_pkg::reg_addr_t   mem_dest,
	input  logic                  mem_reg_write,
	input  logic                  mem_mem_read,
	input  logic                  mem_valid,
	input  mips_pkg::word_t       mem_data,
	// instruction in writeback
	input  mips_pkg::reg_addr_t   wb_dest,
	input  logic                  wb_reg_write,
	input  logic                  wb_valid,
	input  mips_pkg::word_t       wb_data,
	output mips_pkg::reg_addr_t   rf_addr_a,
	output mips_pkg::reg_addr_t   rf_addr_b,
	input  mips_pkg::word_t       rf_data_a,
	input  mips_pkg::word_t       rf_data_b,
	output logic                  stall,
	output logic                  redirect,
	output mips_pkg::word_t       target,
	output mips_pkg::de_payload_t payload
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] shamt;
	logic [15:0] imm;
	logic [25:0] index;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;

	mips_pkg::alu_op_e alu_op;
	mips_pkg::wb_sel_e wb_sel;
	mips_pkg::reg_addr_t dest;
	logic use_imm;
	logic zero_ext;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic use_rs;
	logic use_rt;
	logic is_branch;
	logic is_bne;
	logic is_jump;

	mips_pkg::fwd_sel_e sel_a;
	mips_pkg::fwd_sel_e sel_b;
	mips_pkg::word_t src_a;
	mips_pkg::word_t src_b;
	mips_pkg::word_t imm_ext;
	mips_pkg::word_t pc_plus4;
	logic taken;
	logic hit_ex_a;
	logic hit_ex_b;
	logic hit_mem_load;

	assign opcode = inst[31:26];
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign shamt  = inst[10:6];
	assign funct  = inst[5:0];
	assign imm    = inst[15:0];
	assign index  = inst[25:0];

	////////////////////////////////////////////////////////////////////////////
	// control

	always_comb begin
		alu_op    = mips_pkg::ALU_ADD;
		wb_sel    = mips_pkg::WB_ALU;
		dest      = rt;
		use_imm   = 1'b1;
		zero_ext  = 1'b0;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		use_rs    = 1'b0;
		use_rt    = 1'b0;
		is_branch = 1'b0;
		is_bne    = 1'b0;
		is_jump   = 1'b0;
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				dest      = rd;
				use_imm   = 1'b0;
				reg_write = 1'b1;
				use_rs    = 1'b1;
				use_rt    = 1'b1;
				case (funct)
					mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLL: begin
						alu_op = mips_pkg::ALU_SLL;
						use_rs = 1'b0;
					end
					default: reg_write = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDIU: begin
				reg_write = 1'b1;
				use_rs    = 1'b1;
			end
			mips_pkg::OP_ORI: begin
				alu_op    = mips_pkg::ALU_OR;
				zero_ext  = 1'b1;
				reg_write = 1'b1;
				use_rs    = 1'b1;
			end
			mips_pkg::OP_LUI: begin
				alu_op    = mips_pkg::ALU_LUI;
				reg_write = 1'b1;
			end
			mips_pkg::OP_LW: begin
				wb_sel    = mips_pkg::WB_MEM;
				reg_write = 1'b1;
				mem_read  = 1'b1;
				use_rs    = 1'b1;
			end
			mips_pkg::OP_SW: begin
				mem_write = 1'b1;
				use_rs    = 1'b1;
				use_rt    = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				is_branch = 1'b1;
				is_bne    = opcode == mips_pkg::OP_BNE;
				use_rs    = 1'b1;
				use_rt    = 1'b1;
			end
			mips_pkg::OP_J: is_jump = 1'b1;
			default: ;
		endcase
	end

	assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	////////////////////////////////////////////////////////////////////////////
	// operand forwarding

	function automatic mips_pkg::fwd_sel_e pick_src(input mips_pkg::reg_addr_t src);
		if (src == '0) begin
			return mips_pkg::FWD_RF;
		end
		if (mem_valid && mem_reg_write && mem_dest == src) begin
			return mips_pkg::FWD_MEM;
		end
		if (wb_valid && wb_reg_write && wb_dest == src) begin
			return mips_pkg::FWD_WB;
		end
		return mips_pkg::FWD_RF;
	endfunction

	function automatic mips_pkg::word_t fwd_value(
		input mips_pkg::fwd_sel_e sel,
		input mips_pkg::word_t    rf_value
	);
		case (sel)
			mips_pkg::FWD_MEM: return mem_data;
			mips_pkg::FWD_WB:  return wb_data;
			default:           return rf_value;
		endcase
	endfunction

	assign rf_addr_a = rs;
	assign rf_addr_b = rt;
	assign sel_a = pick_src(rs);
	assign sel_b = pick_src(rt);
	assign src_a = fwd_value(sel_a, rf_data_a);
	assign src_b = fwd_value(sel_b, rf_data_b);

	////////////////////////////////////////////////////////////////////////////
	// hazards and branches

	// execute result is picked up one stage later, in execute
	assign hit_ex_a = use_rs && ex_valid && ex_reg_write && ex_dest != '0 && ex_dest == rs;
	assign hit_ex_b = use_rt && ex_valid && ex_reg_write && ex_dest != '0 && ex_dest == rt;

	// a branch does not compare on freshly loaded data
	assign hit_mem_load = mem_valid && mem_mem_read && mem_dest != '0 &&
		(mem_dest == rs || mem_dest == rt);

	assign stall = in_valid && (
		(ex_mem_read && (hit_ex_a || hit_ex_b)) ||
		(is_branch && (hit_ex_a || hit_ex_b || hit_mem_load)));

	assign pc_plus4 = pc + 32'd4;
	assign taken = (src_a == src_b) != is_bne;
	assign target = is_jump ? {pc_plus4[31:28], index, 2'b00}
		: pc_plus4 + {imm_ext[29:0], 2'b00};
	assign redirect = in_valid && !stall && (is_jump || (is_branch && taken));

	always_comb begin
		payload.pc        = pc;
		payload.op_a      = src_a;
		payload.op_b      = src_b;
		payload.imm       = imm_ext;
		payload.shamt     = shamt;
		payload.alu_op    = alu_op;
		payload.use_imm   = use_imm;
		payload.fwd_a     = hit_ex_a;
		payload.fwd_b     = hit_ex_b;
		payload.dest      = dest;
		payload.reg_write = reg_write;
		payload.mem_read  = mem_read;
		payload.mem_write = mem_write;
		payload.wb_sel    = wb_sel;
	end

endmodule

`default_nettype wire

//--- mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
	input  logic                clk,
	input  mips_pkg::reg_addr_t rd_addr_a,
	output mips_pkg::word_t     rd_data_a,
	input  mips_pkg::reg_addr_t rd_addr_b,
	output mips_pkg::word_t     rd_data_b,
	input  logic                wr_en,
	input  mips_pkg::reg_addr_t wr_addr,
	input  mips_pkg::word_t     wr_data
);

	mips_pkg::word_t regs [mips_pkg::REG_COUNT];

	// r0 reads zero, a same-cycle write is passed through
	function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (wr_en && wr_addr == addr) begin
			return wr_data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data_a = read_port(rd_addr_a);
	assign rd_data_b = read_port(rd_addr_b);

endmodule

`default_nettype wire

//--- mips_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module mips_fetch (
	input  logic            clk,
	input  logic            rst,
	input  logic            hold,
	input  logic            redirect,
	input  mips_pkg::word_t target,
	output mips_pkg::word_t pc,
	output logic            inst_sram_en,
	output mips_pkg::word_t inst_sram_addr
);

	mips_pkg::word_t next_pc;

	// branch target replaces the sequential address after the delay slot
	assign next_pc = redirect ? target : pc + 32'd4;

	// point the sram at the reset vector while in reset,
	// so that word is already returned on the first cycle out of reset
	assign inst_sram_addr = rst ? mips_pkg::PC_RESET : next_pc;

	// no request while held, the sram keeps its last word
	assign inst_sram_en = !hold;

	// pc of the word on inst_sram_rdata
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= mips_pkg::PC_RESET;
		end else if (!hold) begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

//--- mips_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     hold,
	input  logic     bubble,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (!hold) begin
			// a bubble drops the incoming entry
			out_valid <= in_valid && !bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			out_data <= in_data;
		end
	end

endmodule

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int XLEN = 32;
	localparam int REG_COUNT = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

	// first fetched address
	localparam word_t PC_RESET = 32'h0000_0000;

	////////////////////////////////////////////////////////////////////////////
	// opcodes and funct codes

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	////////////////////////////////////////////////////////////////////////////
	// control encodings

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_e;

	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wb_sel_e;

	typedef enum logic [1:0] {
		FWD_RF,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	////////////////////////////////////////////////////////////////////////////
	// stage payloads

	typedef struct packed {
		word_t     pc;
		word_t     op_a;
		word_t     op_b;
		word_t     imm;
		logic [4:0] shamt;
		alu_op_e   alu_op;
		logic      use_imm;
		// operand comes from the instruction now in memory
		logic      fwd_a;
		logic      fwd_b;
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		wb_sel_e   wb_sel;
	} de_payload_t;

	typedef struct packed {
		word_t     pc;
		word_t     alu;
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_read;
		wb_sel_e   wb_sel;
	} em_payload_t;

	typedef struct packed {
		word_t     pc;
		reg_addr_t dest;
		logic      reg_write;
		word_t     data;
	} mw_payload_t;

endpackage

`default_nettype wire
